/* include/rx_ctrl_cfg.svh */
// Build-time settings of the receive command controller.
// Included by the RTL that decodes the settings bus or sizes its queues.
// Offsets are added to the base to form the register addresses.

`ifndef RX_CTRL_CFG_SVH
`define RX_CTRL_CFG_SVH

// Settings address of the command word.
`define RX_CTRL_BASE 8'd0

// Register offsets from the base.
`define RX_CTRL_OFS_CMD     8'd0
`define RX_CTRL_OFS_TIME_HI 8'd1
`define RX_CTRL_OFS_TIME_LO 8'd2
`define RX_CTRL_OFS_HALT    8'd3

// Command queue holds 32 entries.
`define RX_CMD_DEPTH_LOG2 5

// Error queue holds 32 beats, ten full packets and a bit.
`define RX_ERR_DEPTH_LOG2 5

`endif

/* hdl/rx_ctrl_pkg.sv */
// Types shared by the receive command controller and its testbench.
// Referenced by scoped name from each file that needs them.

package rx_ctrl_pkg;

   // One queued command: control word on top, start time below.
   typedef struct packed {
      logic        send_imm; // Run without waiting for the time.
      logic        chain;    // Take the next command when this one ends.
      logic        reload;   // Repeat when the chain finds nothing.
      logic        stop;     // End streaming.
      logic [27:0] numlines;
      logic [63:0] rcvtime;
   } rx_cmd_t;

   // One beat of the error stream.
   typedef struct packed {
      logic        last;
      logic [63:0] data;
   } err_beat_t;

   // Code carried in the upper half of the last error beat.
   typedef enum logic [31:0] {
      ERR_LATE         = 32'd2,
      ERR_BROKEN_CHAIN = 32'd4,
      ERR_OVERRUN      = 32'd8
   } err_code_t;

   // Sequencer states. Each error has a header, time and data beat.
   typedef enum logic [3:0] {
      IDLE      = 4'd0,
      RUNNING   = 4'd1,
      OVR_HDR   = 4'd2,
      OVR_TIME  = 4'd3,
      OVR_DATA  = 4'd4,
      BRK_HDR   = 4'd5,
      BRK_TIME  = 4'd6,
      BRK_DATA  = 4'd7,
      LATE_HDR  = 4'd8,
      LATE_TIME = 4'd9,
      LATE_DATA = 4'd10
   } seq_state_t;

endpackage

/* hdl/cmd_if.sv */
// Head-of-queue command and halt handshake between the command queue
// and the sequencer. The queue offers, the sequencer pops.

`timescale 1ns/1ps

interface cmd_if;

   logic                  cmd_valid; // Head entry present.
   rx_ctrl_pkg::rx_cmd_t  cmd;       // Head entry.
   logic                  halt;      // Halt requested by the host.
   logic                  cmd_pop;   // One-cycle pop of the head.
   logic                  halt_done; // Clears halt and flushes the queue.

   modport queue (
      output cmd_valid, cmd, halt,
      input  cmd_pop, halt_done
   );

   modport seq (
      input  cmd_valid, cmd, halt,
      output cmd_pop, halt_done
   );

endinterface

/* hdl/stream_fifo.sv */
// Short first-word-fall-through FIFO with valid/ready on both sides.
// The payload type is a parameter, so one block serves commands and error beats.
// i_clear empties it on the next edge.

`timescale 1ns/1ps

module stream_fifo #(
   parameter type T          = rx_ctrl_pkg::err_beat_t,
   parameter int  DEPTH_LOG2 = 5
) (
   input  logic clk,
   input  logic i_rst_n,
   input  logic i_clear,
   input  T     i_data,
   input  logic i_valid,
   output logic o_ready,
   output T     o_data,
   output logic o_valid,
   input  logic i_ready
);

   localparam logic [DEPTH_LOG2:0] DEPTH = 1 << DEPTH_LOG2;

   T                      mem [DEPTH];
   logic [DEPTH_LOG2-1:0] wr_ptr;
   logic [DEPTH_LOG2-1:0] rd_ptr;
   logic [DEPTH_LOG2:0]   count;
   logic                  push;
   logic                  pop;

   assign o_ready = (count != DEPTH); // Space left.
   assign o_valid = (count != '0);
   assign o_data  = mem[rd_ptr];      // Head shows without a read.

   assign push = i_valid & o_ready;
   assign pop  = o_valid & i_ready;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= i_data;
      end
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (i_clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop)  rd_ptr <= rd_ptr + 1'b1;
         // Pointers wrap on their own; count tracks occupancy.
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

/* hdl/rx_cmd_queue.sv */
// Settings-bus side of the controller.
// Assembles a command from the command word and the two time words,
// queues it on the time-low write, and keeps the host's halt request.

`timescale 1ns/1ps

`include "rx_ctrl_cfg.svh"

module rx_cmd_queue (
   input  logic        clk,
   input  logic        i_rst_n,
   input  logic        i_clear,
   input  logic        i_set_stb,
   input  logic [7:0]  i_set_addr,
   input  logic [31:0] i_set_data,
   cmd_if.queue        cq
);

   logic [31:0]          cmd_word;
   logic [31:0]          time_hi;
   logic                 wr_cmd;
   logic                 wr_time_hi;
   logic                 wr_time_lo;
   logic                 wr_halt;
   rx_ctrl_pkg::rx_cmd_t new_cmd;

   assign wr_cmd     = i_set_stb && (i_set_addr == `RX_CTRL_BASE + `RX_CTRL_OFS_CMD);
   assign wr_time_hi = i_set_stb && (i_set_addr == `RX_CTRL_BASE + `RX_CTRL_OFS_TIME_HI);
   assign wr_time_lo = i_set_stb && (i_set_addr == `RX_CTRL_BASE + `RX_CTRL_OFS_TIME_LO);
   assign wr_halt    = i_set_stb && (i_set_addr == `RX_CTRL_BASE + `RX_CTRL_OFS_HALT);

   // Command and upper time wait here for the time-low write.
   always_ff @(posedge clk) begin
      if (wr_cmd)     cmd_word <= i_set_data;
      if (wr_time_hi) time_hi  <= i_set_data;
   end

   // Flags and line count sit in the command word, same order as the struct.
   assign new_cmd = rx_ctrl_pkg::rx_cmd_t'({cmd_word, time_hi, i_set_data});

   // Halt stays set until the sequencer acts on it.
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         cq.halt <= 1'b0;
      end else if (i_clear || cq.halt_done) begin
         cq.halt <= 1'b0;
      end else if (wr_halt) begin
         cq.halt <= 1'b1;
      end
   end

   // A write to a full queue is dropped, the bus cannot wait.
   stream_fifo #(
      .T          (rx_ctrl_pkg::rx_cmd_t),
      .DEPTH_LOG2 (`RX_CMD_DEPTH_LOG2)
   ) i_cmd_fifo (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_clear (i_clear | cq.halt_done), // Halt flushes pending commands.
      .i_data  (new_cmd),
      .i_valid (wr_time_lo),
      .o_ready (),
      .o_data  (cq.cmd),
      .o_valid (cq.cmd_valid),
      .i_ready (cq.cmd_pop)
   );

endmodule

/* hdl/rx_cmd_sequencer.sv */
// Runs queued commands against the sample path.
// Starts a command at once or at its time, counts sample lines, then ends,
// chains or repeats. Failures go out as three-beat error packets.

`timescale 1ns/1ps

module rx_cmd_sequencer (
   input  logic                   clk,
   input  logic                   i_rst_n,
   input  logic                   i_clear,
   input  logic [63:0]            i_vita_time,
   input  logic                   i_strobe,
   input  logic                   i_full,
   input  logic [11:0]            i_seqnum,
   input  logic [31:0]            i_sid,
   cmd_if.seq                     cs,
   output logic                   o_run,
   output logic                   o_eob,
   output rx_ctrl_pkg::err_beat_t o_err_beat,
   output logic                   o_err_valid,
   input  logic                   i_err_ready
);

   rx_ctrl_pkg::seq_state_t state;
   rx_ctrl_pkg::seq_state_t state_nxt;
   rx_ctrl_pkg::err_code_t  err_code;
   logic [27:0]             lines_left;
   logic [27:0]             repeat_lines;
   logic                    chain_sav;
   logic                    reload_sav;
   logic                    now;
   logic                    late;
   logic                    last_line;
   logic                    load_cmd;
   logic                    reload_cmd;
   logic                    count_dn;

   // Head command's time against the sample clock.
   assign now       = (i_vita_time == cs.cmd.rcvtime);
   assign late      = (i_vita_time > cs.cmd.rcvtime);
   assign last_line = (lines_left == 28'd1);

   always_comb begin
      state_nxt    = state;
      cs.cmd_pop   = 1'b0;
      cs.halt_done = 1'b0;
      load_cmd     = 1'b0;
      reload_cmd   = 1'b0;
      count_dn     = 1'b0;
      case (state)
         rx_ctrl_pkg::IDLE: begin
            if (cs.cmd_valid) begin
               if (cs.cmd.stop) begin
                  cs.cmd_pop = 1'b1; // Consume it, stay idle.
               end else if (late && !cs.cmd.send_imm) begin
                  cs.cmd_pop = 1'b1;
                  state_nxt  = rx_ctrl_pkg::LATE_HDR;
               end else if (now || cs.cmd.send_imm) begin
                  cs.cmd_pop = 1'b1;
                  load_cmd   = 1'b1;
                  state_nxt  = rx_ctrl_pkg::RUNNING;
               end
            end
         end
         rx_ctrl_pkg::RUNNING: begin
            if (i_strobe) begin
               if (i_full) begin
                  state_nxt = rx_ctrl_pkg::OVR_HDR; // Framing buffer overran.
               end else if (last_line) begin
                  if (cs.halt) begin
                     cs.halt_done = 1'b1;
                     state_nxt    = rx_ctrl_pkg::IDLE;
                  end else if (chain_sav) begin
                     if (cs.cmd_valid) begin
                        cs.cmd_pop = 1'b1;
                        load_cmd   = 1'b1;
                        if (cs.cmd.stop) state_nxt = rx_ctrl_pkg::IDLE;
                     end else if (reload_sav) begin
                        reload_cmd = 1'b1;
                     end else begin
                        state_nxt = rx_ctrl_pkg::BRK_HDR;
                     end
                  end else begin
                     state_nxt = rx_ctrl_pkg::IDLE;
                  end
               end else begin
                  count_dn = 1'b1;
               end
            end
         end
         // Error beats step only when the error queue takes them.
         rx_ctrl_pkg::OVR_HDR:   if (i_err_ready) state_nxt = rx_ctrl_pkg::OVR_TIME;
         rx_ctrl_pkg::OVR_TIME:  if (i_err_ready) state_nxt = rx_ctrl_pkg::OVR_DATA;
         rx_ctrl_pkg::OVR_DATA:  if (i_err_ready) state_nxt = rx_ctrl_pkg::IDLE;
         rx_ctrl_pkg::BRK_HDR:   if (i_err_ready) state_nxt = rx_ctrl_pkg::BRK_TIME;
         rx_ctrl_pkg::BRK_TIME:  if (i_err_ready) state_nxt = rx_ctrl_pkg::BRK_DATA;
         rx_ctrl_pkg::BRK_DATA:  if (i_err_ready) state_nxt = rx_ctrl_pkg::IDLE;
         rx_ctrl_pkg::LATE_HDR:  if (i_err_ready) state_nxt = rx_ctrl_pkg::LATE_TIME;
         rx_ctrl_pkg::LATE_TIME: if (i_err_ready) state_nxt = rx_ctrl_pkg::LATE_DATA;
         rx_ctrl_pkg::LATE_DATA: if (i_err_ready) state_nxt = rx_ctrl_pkg::IDLE;
         default:                state_nxt = rx_ctrl_pkg::IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state        <= rx_ctrl_pkg::IDLE;
         lines_left   <= '0;
         repeat_lines <= '0;
         chain_sav    <= 1'b0;
         reload_sav   <= 1'b0;
      end else if (i_clear) begin
         state        <= rx_ctrl_pkg::IDLE;
         lines_left   <= '0;
         repeat_lines <= '0;
         chain_sav    <= 1'b0;
         reload_sav   <= 1'b0;
      end else begin
         state <= state_nxt;
         if (load_cmd) begin
            lines_left   <= cs.cmd.numlines;
            repeat_lines <= cs.cmd.numlines; // Kept for reload.
            chain_sav    <= cs.cmd.chain;
            reload_sav   <= cs.cmd.reload;
         end else if (reload_cmd) begin
            lines_left <= repeat_lines;
         end else if (count_dn) begin
            lines_left <= lines_left - 28'd1;
         end
      end
   end

   assign o_run = (state == rx_ctrl_pkg::RUNNING);

   // Burst ends here unless the stream carries on into more lines.
   assign o_eob = o_run && i_strobe && last_line &&
                  (!chain_sav || (cs.cmd_valid && cs.cmd.stop) ||
                   (!cs.cmd_valid && !reload_sav) || cs.halt);

   always_comb begin
      o_err_beat  = '0;
      o_err_valid = 1'b1;
      err_code    = rx_ctrl_pkg::ERR_OVERRUN;
      case (state)
         rx_ctrl_pkg::BRK_DATA:  err_code = rx_ctrl_pkg::ERR_BROKEN_CHAIN;
         rx_ctrl_pkg::LATE_DATA: err_code = rx_ctrl_pkg::ERR_LATE;
         default:                err_code = rx_ctrl_pkg::ERR_OVERRUN;
      endcase
      case (state)
         rx_ctrl_pkg::OVR_HDR, rx_ctrl_pkg::BRK_HDR, rx_ctrl_pkg::LATE_HDR: begin
            o_err_beat.data = {4'hF, i_seqnum, 16'd24, i_sid}; // Packet header.
         end
         rx_ctrl_pkg::OVR_TIME, rx_ctrl_pkg::BRK_TIME, rx_ctrl_pkg::LATE_TIME: begin
            o_err_beat.data = i_vita_time;
         end
         rx_ctrl_pkg::OVR_DATA, rx_ctrl_pkg::BRK_DATA, rx_ctrl_pkg::LATE_DATA: begin
            o_err_beat.data = {err_code, 32'd0};
            o_err_beat.last = 1'b1;
         end
         default: o_err_valid = 1'b0; // Idle or running.
      endcase
   end

endmodule

/* hdl/rx_control.sv */
// Top level of the receive command controller.
// Host commands come in on the settings bus, the sample path sees run and
// end of burst, and error packets leave on a valid/ready stream.

`timescale 1ns/1ps

`include "rx_ctrl_cfg.svh"

module rx_control (
   input  logic        clk,
   input  logic        i_rst_n,
   input  logic        i_clear,
   input  logic        i_set_stb,
   input  logic [7:0]  i_set_addr,
   input  logic [31:0] i_set_data,
   input  logic [63:0] i_vita_time,
   output logic        o_run,
   output logic        o_eob,
   input  logic        i_strobe,
   input  logic        i_full,
   input  logic [11:0] i_seqnum,
   input  logic [31:0] i_sid,
   output logic [63:0] o_err_tdata,
   output logic        o_err_tlast,
   output logic        o_err_tvalid,
   input  logic        i_err_tready
);

   cmd_if                  cmd_bus ();
   rx_ctrl_pkg::err_beat_t err_beat;
   logic                   err_valid;
   logic                   err_ready;
   rx_ctrl_pkg::err_beat_t err_out;

   rx_cmd_queue i_rx_cmd_queue (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_clear    (i_clear),
      .i_set_stb  (i_set_stb),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .cq         (cmd_bus.queue)
   );

   rx_cmd_sequencer i_rx_cmd_sequencer (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_clear     (i_clear),
      .i_vita_time (i_vita_time),
      .i_strobe    (i_strobe),
      .i_full      (i_full),
      .i_seqnum    (i_seqnum),
      .i_sid       (i_sid),
      .cs          (cmd_bus.seq),
      .o_run       (o_run),
      .o_eob       (o_eob),
      .o_err_beat  (err_beat),
      .o_err_valid (err_valid),
      .i_err_ready (err_ready)
   );

   // Buffers error packets so the host side can stall.
   stream_fifo #(
      .T          (rx_ctrl_pkg::err_beat_t),
      .DEPTH_LOG2 (`RX_ERR_DEPTH_LOG2)
   ) i_err_fifo (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_clear (i_clear),
      .i_data  (err_beat),
      .i_valid (err_valid),
      .o_ready (err_ready),
      .o_data  (err_out),
      .o_valid (o_err_tvalid),
      .i_ready (i_err_tready)
   );

   assign o_err_tdata = err_out.data;
   assign o_err_tlast = err_out.last;

endmodule

/* sim/tb_rx_control.sv */
// Testbench for the receive command controller.
// Random commands from an xorshift source run through the DUT and are
// checked against a model of the command rules. One line per test, then totals.

`timescale 1ns/1ps

`include "rx_ctrl_cfg.svh"

module tb_rx_control;

   logic        clk;
   logic        i_rst_n;
   logic        i_clear;
   logic        i_set_stb;
   logic [7:0]  i_set_addr;
   logic [31:0] i_set_data;
   logic [63:0] i_vita_time;
   logic        o_run;
   logic        o_eob;
   logic        i_strobe;
   logic        i_full;
   logic [11:0] i_seqnum;
   logic [31:0] i_sid;
   logic [63:0] o_err_tdata;
   logic        o_err_tlast;
   logic        o_err_tvalid;
   logic        i_err_tready;

   logic [31:0]            rng;
   logic                   bp_on;            // Random stall on the error stream.
   int                     errors;
   int                     test_errors;
   int                     tests_failed;
   int                     checks;
   int                     run_strobes;      // Strobes seen with o_run high.
   int                     run_cycles;
   int                     eob_count;
   int                     eob_idx;          // Strobe number that carried o_eob.
   logic [63:0]            last_strobe_time;
   rx_ctrl_pkg::err_beat_t beats[$];         // Beats accepted from the error stream.

   rx_control i_rx_control (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Observes at the falling edge, where all outputs have settled.
   always @(negedge clk) begin
      if (o_run) run_cycles++;
      if (o_run && i_strobe) begin
         run_strobes++;
         last_strobe_time = i_vita_time;
         if (o_eob) begin
            eob_count++;
            eob_idx = run_strobes;
         end
      end else if (o_eob) begin
         eob_count++; // End of burst without a running strobe.
         eob_idx = -1;
      end
      if (o_err_tvalid && i_err_tready) beats.push_back({o_err_tlast, o_err_tdata});
   end

   function automatic logic [31:0] next_random();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   // Reload under halt stops on the first last line after the halt is seen.
   function automatic int halt_end(input int seen, input int n);
      return (seen / n + 1) * n;
   endfunction

   task automatic check_flag(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
         test_errors++;
      end
   endtask

   task automatic check_count(input string name, input longint got, input longint exp);
      checks++;
      if (got != exp) begin
         $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
         test_errors++;
      end
   endtask

   task automatic check_beat(input string name, input rx_ctrl_pkg::err_beat_t got,
                             input rx_ctrl_pkg::err_beat_t exp);
      checks++;
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         test_errors++;
      end
   endtask

   task automatic check_code(input string name, input rx_ctrl_pkg::err_code_t got,
                             input rx_ctrl_pkg::err_code_t exp);
      checks++;
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
         test_errors++;
      end
   endtask

   task automatic fail_note(input string msg);
      $display("error at %0t: %s", $time, msg);
      test_errors++;
   endtask

   // One clock step; inputs change 1 ns after the rising edge.
   task automatic next_cycle();
      logic [31:0] r;
      @(posedge clk);
      #1;
      r            = bp_on ? next_random() : 32'd1;
      i_vita_time  = i_vita_time + 64'd1;
      i_set_stb    = 1'b0;
      i_strobe     = 1'b0;
      i_full       = 1'b0;
      i_err_tready = r[0];
   endtask

   task automatic write_reg(input logic [7:0] ofs, input logic [31:0] data);
      next_cycle();
      i_set_stb  = 1'b1;
      i_set_addr = `RX_CTRL_BASE + ofs;
      i_set_data = data;
   endtask

   // Flags are send_imm, chain, reload, stop from the top bit down.
   task automatic write_cmd(input logic [3:0] flags, input int lines, input logic [63:0] t);
      write_reg(`RX_CTRL_OFS_CMD, {flags, 28'(lines)});
      write_reg(`RX_CTRL_OFS_TIME_HI, t[63:32]);
      write_reg(`RX_CTRL_OFS_TIME_LO, t[31:0]);
   endtask

   task automatic clear_counts();
      run_strobes = 0;
      run_cycles  = 0;
      eob_count   = 0;
      eob_idx     = 0;
      beats.delete();
   endtask

   task automatic begin_test();
      test_errors = 0;
      clear_counts();
      i_seqnum = 12'(next_random());
      i_sid    = next_random();
   endtask

   task automatic end_test(input int id, input string name);
      $display("test %0d %s: %s, %0d errors", id, name,
               (test_errors == 0) ? "pass" : "FAIL", test_errors);
      errors += test_errors;
      if (test_errors != 0) tests_failed++;
   endtask

   task automatic wait_run(output logic [63:0] rise);
      int i;
      rise = '0;
      for (i = 0; i < 500; i++) begin
         next_cycle();
         if (o_run) begin
            rise = i_vita_time;
            return;
         end
      end
      fail_note("o_run never went high");
   endtask

   // Strobes with random gaps until o_run falls. Optional halt write or full strobe.
   task automatic drive_burst(input int halt_after, input int full_at, output longint mark);
      int i;
      int gap;
      bit started;
      bit halted;
      gap     = 0;
      started = 1'b0;
      halted  = 1'b0;
      mark    = 0;
      for (i = 0; i < 2000; i++) begin
         next_cycle();
         if (o_run) started = 1'b1;
         else if (started) return;
         if (halt_after > 0 && !halted && run_strobes >= halt_after) begin
            write_halt_now();
            halted = 1'b1;
            mark   = run_strobes;
         end else if (o_run && gap == 0) begin
            i_strobe = 1'b1;
            if (run_strobes == full_at) begin
               i_full = 1'b1;
               mark   = i_vita_time;
            end
            gap = int'(next_random() % 4);
         end else if (gap > 0) begin
            gap--;
         end
      end
      fail_note("burst did not end in time");
   endtask

   task automatic write_halt_now();
      i_set_stb  = 1'b1;
      i_set_addr = `RX_CTRL_BASE + `RX_CTRL_OFS_HALT;
      i_set_data = 32'd0;
   endtask

   task automatic wait_beats(input int n);
      int i;
      for (i = 0; i < 500 && beats.size() < n; i++) next_cycle();
      if (beats.size() < n) fail_note("error packet did not arrive");
      repeat (8) next_cycle(); // Room for stray extra beats.
      check_count("error beat count", beats.size(), n);
   endtask

   // Header, time, then the code with last set.
   task automatic check_packet(input rx_ctrl_pkg::err_code_t code, input logic [63:0] t);
      if (beats.size() < 3) return;
      check_beat("header beat", beats[0], {1'b0, 4'hF, i_seqnum, 16'd24, i_sid});
      check_beat("time beat", beats[1], {1'b0, t});
      check_beat("code beat", beats[2], {1'b1, 32'(code), 32'd0});
      check_code("error code", rx_ctrl_pkg::err_code_t'(beats[2].data[63:32]), code);
   endtask

   initial begin
      int          n;
      int          m;
      int          k;
      longint      mark;
      logic [63:0] t;
      logic [63:0] wr;
      rng          = 32'd97;
      bp_on        = 1'b0;
      errors       = 0;
      tests_failed = 0;
      checks       = 0;
      i_rst_n      = 1'b0;
      i_clear      = 1'b0;
      i_set_stb    = 1'b0;
      i_set_addr   = 8'd0;
      i_set_data   = 32'd0;
      i_vita_time  = 64'd0;
      i_strobe     = 1'b0;
      i_full       = 1'b0;
      i_seqnum     = 12'd0;
      i_sid        = 32'd0;
      i_err_tready = 1'b1;
      clear_counts();
      repeat (16) next_cycle();
      i_rst_n = 1'b1;

      begin_test();
      check_flag("o_run after reset", o_run, 1'b0);
      check_flag("o_eob after reset", o_eob, 1'b0);
      check_flag("o_err_tvalid after reset", o_err_tvalid, 1'b0);
      n = 1 + int'(next_random() % 20);
      write_cmd(4'b1000, n, 64'd0);
      next_cycle();
      check_flag("o_run one cycle after write", o_run, 1'b0);
      next_cycle();
      check_flag("o_run two cycles after write", o_run, 1'b1);
      drive_burst(0, -1, mark);
      check_count("strobes with o_run", run_strobes, n);
      check_count("o_eob strobe", eob_idx, n);
      check_count("o_eob count", eob_count, 1);
      wait_beats(0);
      end_test(1, "immediate command");

      begin_test();
      n = 1 + int'(next_random() % 20);
      m = 1 + int'(next_random() % 20);
      k = 1 + int'(next_random() % 20);
      write_cmd(4'b1100, n, 64'd0);
      write_cmd(4'b1100, m, 64'd0);
      write_cmd(4'b1000, k, 64'd0);
      drive_burst(0, -1, mark);
      check_count("strobes with o_run", run_strobes, n + m + k);
      check_count("o_eob strobe", eob_idx, n + m + k);
      check_count("o_eob count", eob_count, 1);
      wait_beats(0);
      end_test(2, "chain of three");

      begin_test();
      n = 1 + int'(next_random() % 20);
      t = i_vita_time + 64'd20 + 64'(next_random() % 10);
      write_cmd(4'b0000, n, t);
      wait_run(wr);
      check_count("o_run rise time", wr, t + 64'd1);
      drive_burst(0, -1, mark);
      check_count("strobes with o_run", run_strobes, n);
      check_count("o_eob strobe", eob_idx, n);
      clear_counts();
      write_cmd(4'b0000, 4, i_vita_time - 64'd5);
      wr = i_vita_time;
      wait_beats(3);
      check_packet(rx_ctrl_pkg::ERR_LATE, wr + 64'd3); // Seen one cycle on, time two later.
      check_count("cycles with o_run after late command", run_cycles, 0);
      end_test(3, "timed and late commands");

      begin_test();
      n = 1 + int'(next_random() % 20);
      write_cmd(4'b1110, n, 64'd0);
      drive_burst(1 + int'(next_random() % (3 * n)), -1, mark);
      check_count("strobes with o_run", run_strobes, halt_end(int'(mark), n));
      check_count("o_eob strobe", eob_idx, halt_end(int'(mark), n));
      check_count("o_eob count", eob_count, 1);
      wait_beats(0);
      clear_counts();
      m = 1 + int'(next_random() % 20);
      write_cmd(4'b1000, m, 64'd0);
      drive_burst(0, -1, mark);
      check_count("strobes after halt", run_strobes, m);
      check_count("o_eob strobe after halt", eob_idx, m);
      end_test(4, "reload until halt");

      begin_test();
      n = 1 + int'(next_random() % 20);
      write_cmd(4'b1100, n, 64'd0);
      drive_burst(0, -1, mark);
      check_count("strobes with o_run", run_strobes, n);
      check_count("o_eob strobe", eob_idx, n);
      wait_beats(3);
      check_packet(rx_ctrl_pkg::ERR_BROKEN_CHAIN, last_strobe_time + 64'd2);
      end_test(5, "broken chain");

      begin_test();
      bp_on = 1'b1;
      n = 2 + int'(next_random() % 19);
      k = int'(next_random() % (n - 1)); // Never the last line.
      write_cmd(4'b1000, n, 64'd0);
      drive_burst(0, k, mark);
      check_count("strobes with o_run", run_strobes, k + 1);
      check_count("o_eob count", eob_count, 0);
      wait_beats(3);
      check_packet(rx_ctrl_pkg::ERR_OVERRUN, 64'(mark) + 64'd2);
      bp_on = 1'b0;
      end_test(6, "overrun under back-pressure");

      $display("tests 6, failed %0d, checks %0d, errors %0d", tests_failed, checks, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

/* vlog.f */
+incdir+include
hdl/rx_ctrl_pkg.sv
hdl/cmd_if.sv
hdl/stream_fifo.sv
hdl/rx_cmd_queue.sv
hdl/rx_cmd_sequencer.sv
hdl/rx_control.sv
sim/tb_rx_control.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and judges the run from its log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing -Wno-fatal --top-module tb_rx_control -f vlog.f \
   -o tb_rx_control > build.log 2>&1 \
   || { cat build.log; echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_rx_control > sim.log 2>&1 \
   || echo "Simulation exited with an error status" >> sim.log
cat sim.log
grep -q "Something failed" sim.log && { echo "RESULT: FAIL"; exit 1; }
grep -q "Everything OK" sim.log && { echo "RESULT: PASS"; exit 0; } \
   || { echo "RESULT: FAIL"; exit 1; }
